//--- common/cc_params.svh
`ifndef CC_PARAMS_SVH
`define CC_PARAMS_SVH

// Width of one dependency set
// Each bit stands for one shared resource of the scheduler
`define CC_DEP_WIDTH 256

// Width of the owner ID carried with every transaction
`define CC_OWNER_WIDTH 64

// Slice handled by one parallel comparator in the conflict engine
// Must divide CC_DEP_WIDTH evenly
`define CC_CHUNK_WIDTH 64

// Width of each statistics counter
`define CC_CNT_WIDTH 32

`endif

//--- common/cc_pkg.sv
`include "cc_params.svh"

`default_nettype none

package cc_pkg;

    // One transaction as it travels on both streams
    typedef struct packed {
        logic [`CC_OWNER_WIDTH-1:0] owner;
        logic [`CC_DEP_WIDTH-1:0]   rd_deps;
        logic [`CC_DEP_WIDTH-1:0]   wr_deps;
    } cc_txn_t;

    // Conflict types found for the held transaction
    typedef struct packed {
        logic raw;
        logic waw;
        logic war;
    } cc_verdict_t;

    // Cumulative statistics, cleared only by reset
    typedef struct packed {
        logic [`CC_CNT_WIDTH-1:0] raw_cnt;
        logic [`CC_CNT_WIDTH-1:0] waw_cnt;
        logic [`CC_CNT_WIDTH-1:0] war_cnt;
        logic [`CC_CNT_WIDTH-1:0] filtered_cnt;
        logic [`CC_CNT_WIDTH-1:0] processed_cnt;
    } cc_stats_t;

endpackage

`default_nettype wire

//--- conflict_engine/conflict_detect.sv
`include "cc_params.svh"

`default_nettype none

module conflict_detect #(
    parameter int CHUNK_WIDTH = `CC_CHUNK_WIDTH
) (
    input  cc_pkg::cc_txn_t          cur_txn,
    input  logic [`CC_DEP_WIDTH-1:0] batch_rd,
    input  logic [`CC_DEP_WIDTH-1:0] batch_wr,
    output cc_pkg::cc_verdict_t      verdict
);

    localparam int NUM_CHUNKS = `CC_DEP_WIDTH / CHUNK_WIDTH;

    // Per-chunk overlap flags
    logic [NUM_CHUNKS-1:0] raw_chunk;
    logic [NUM_CHUNKS-1:0] waw_chunk;
    logic [NUM_CHUNKS-1:0] war_chunk;

    for (genvar c = 0; c < NUM_CHUNKS; c++) begin : g_chunk
        logic [CHUNK_WIDTH-1:0] rd_slice;
        logic [CHUNK_WIDTH-1:0] wr_slice;
        logic [CHUNK_WIDTH-1:0] batch_rd_slice;
        logic [CHUNK_WIDTH-1:0] batch_wr_slice;

        assign rd_slice       = cur_txn.rd_deps[c*CHUNK_WIDTH +: CHUNK_WIDTH];
        assign wr_slice       = cur_txn.wr_deps[c*CHUNK_WIDTH +: CHUNK_WIDTH];
        assign batch_rd_slice = batch_rd[c*CHUNK_WIDTH +: CHUNK_WIDTH];
        assign batch_wr_slice = batch_wr[c*CHUNK_WIDTH +: CHUNK_WIDTH];

        // Read after write: new reads hit resources already written in the batch
        assign raw_chunk[c] = |(rd_slice & batch_wr_slice);

        // Write after write
        assign waw_chunk[c] = |(wr_slice & batch_wr_slice);

        // Write after read: new writes hit resources the batch reads
        assign war_chunk[c] = |(wr_slice & batch_rd_slice);
    end

    // Any chunk with an overlap flags the whole transaction
    always_comb begin
        verdict.raw = |raw_chunk;
        verdict.waw = |waw_chunk;
        verdict.war = |war_chunk;
    end

endmodule

`default_nettype wire

//--- conflict_engine/dep_tracker.sv
`include "cc_params.svh"

`default_nettype none

module dep_tracker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     commit,
    input  logic                     batch_done,
    input  cc_pkg::cc_txn_t          cur_txn,
    output logic [`CC_DEP_WIDTH-1:0] batch_rd,
    output logic [`CC_DEP_WIDTH-1:0] batch_wr
);

    // Union of all committed read and write sets in the current batch
    logic [`CC_DEP_WIDTH-1:0] rd_set;
    logic [`CC_DEP_WIDTH-1:0] wr_set;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_set <= '0;
            wr_set <= '0;
        end else if (batch_done) begin
            // End of batch wins over a commit on the same edge
            rd_set <= '0;
            wr_set <= '0;
        end else if (commit) begin
            rd_set <= rd_set | cur_txn.rd_deps;
            wr_set <= wr_set | cur_txn.wr_deps;
        end
    end

    assign batch_rd = rd_set;
    assign batch_wr = wr_set;

endmodule

`default_nettype wire

//--- src/txn_control.sv
`default_nettype none

module txn_control (
    input  logic                clk,
    input  logic                rst_n,

    // Input stream
    input  logic                s_valid,
    output logic                s_ready,
    input  cc_pkg::cc_txn_t     s_txn,

    // Output stream
    output logic                m_valid,
    input  logic                m_ready,
    output cc_pkg::cc_txn_t     m_txn,

    // Conflict engine side
    input  cc_pkg::cc_verdict_t verdict,
    output cc_pkg::cc_txn_t     cur_txn,
    output logic                check,
    output logic                commit
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_OUTPUT
    } state_t;

    state_t state;
    state_t state_nxt;

    cc_pkg::cc_txn_t txn_q;

    logic accept;
    logic has_conflict;
    logic out_done;

    assign accept       = s_valid && s_ready;
    assign has_conflict = verdict.raw || verdict.waw || verdict.war;
    assign out_done     = m_valid && m_ready;

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_CHECK;
                end
            end
            ST_CHECK: begin
                // Verdict is only meaningful here, one cycle after capture
                if (has_conflict) begin
                    state_nxt = ST_IDLE;
                end else begin
                    state_nxt = ST_OUTPUT;
                end
            end
            ST_OUTPUT: begin
                if (out_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Held transaction, stable from capture until the output transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            txn_q <= s_txn;
        end
    end

    // Handshakes follow the state directly
    assign s_ready = (state == ST_IDLE);
    assign m_valid = (state == ST_OUTPUT);
    assign m_txn   = txn_q;

    assign cur_txn = txn_q;
    assign check   = (state == ST_CHECK);

    // Batch sets take the transaction only once the sink has it
    assign commit  = out_done;

endmodule

`default_nettype wire

//--- src/perf_counters.sv
`include "cc_params.svh"

`default_nettype none

module perf_counters (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                check,
    input  cc_pkg::cc_verdict_t verdict,
    output cc_pkg::cc_stats_t   stats
);

    localparam logic [`CC_CNT_WIDTH-1:0] ONE = `CC_CNT_WIDTH'(1);

    cc_pkg::cc_stats_t cnt;

    logic filtered;

    // A transaction is filtered once, however many conflict types it has
    assign filtered = verdict.raw || verdict.waw || verdict.war;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (check) begin
            cnt.processed_cnt <= cnt.processed_cnt + ONE;
            if (verdict.raw) begin
                cnt.raw_cnt <= cnt.raw_cnt + ONE;
            end
            if (verdict.waw) begin
                cnt.waw_cnt <= cnt.waw_cnt + ONE;
            end
            if (verdict.war) begin
                cnt.war_cnt <= cnt.war_cnt + ONE;
            end
            if (filtered) begin
                cnt.filtered_cnt <= cnt.filtered_cnt + ONE;
            end
        end
    end

    // Counters run across batches, batch_done does not touch them
    assign stats = cnt;

endmodule

`default_nettype wire

//--- src/conflict_checker.sv
`include "cc_params.svh"

`default_nettype none

module conflict_checker (
    input  logic              clk,
    input  logic              rst_n,

    // Incoming transactions
    input  logic              s_valid,
    output logic              s_ready,
    input  cc_pkg::cc_txn_t   s_txn,

    // Forwarded conflict-free transactions
    output logic              m_valid,
    input  logic              m_ready,
    output cc_pkg::cc_txn_t   m_txn,

    input  logic              batch_done,
    output cc_pkg::cc_stats_t stats
);

    cc_pkg::cc_txn_t     cur_txn;
    cc_pkg::cc_verdict_t verdict;

    logic check;
    logic commit;

    logic [`CC_DEP_WIDTH-1:0] batch_rd;
    logic [`CC_DEP_WIDTH-1:0] batch_wr;

    txn_control i_txn_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_txn   (s_txn),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_txn   (m_txn),
        .verdict (verdict),
        .cur_txn (cur_txn),
        .check   (check),
        .commit  (commit)
    );

    conflict_detect #(
        .CHUNK_WIDTH (`CC_CHUNK_WIDTH)
    ) i_conflict_detect (
        .cur_txn  (cur_txn),
        .batch_rd (batch_rd),
        .batch_wr (batch_wr),
        .verdict  (verdict)
    );

    dep_tracker i_dep_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .commit     (commit),
        .batch_done (batch_done),
        .cur_txn    (cur_txn),
        .batch_rd   (batch_rd),
        .batch_wr   (batch_wr)
    );

    perf_counters i_perf_counters (
        .clk     (clk),
        .rst_n   (rst_n),
        .check   (check),
        .verdict (verdict),
        .stats   (stats)
    );

endmodule

`default_nettype wire

//--- testbench/conflict_checker_chk.sv
`default_nettype none

module conflict_checker_chk (
    input logic            clk,
    input logic            rst_n,
    input logic            s_ready,
    input logic            m_valid,
    input logic            m_ready,
    input cc_pkg::cc_txn_t m_txn
);

    timeunit 1ns;
    timeprecision 100ps;

    // A presented transaction holds until the sink takes it
    a_m_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_txn)))
        else $error("m_valid or m_txn changed before m_ready");

    // Accept and output never overlap in the sequential loop
    a_one_side: assert property (@(posedge clk) disable iff (!rst_n)
        !(s_ready && m_valid))
        else $error("s_ready and m_valid high together");

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !m_valid)
        else $error("m_valid high during reset");

    a_reset_release: assert property (@(posedge clk) $rose(rst_n) |-> !m_valid)
        else $error("m_valid high right after reset release");

endmodule

bind conflict_checker conflict_checker_chk i_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_txn   (m_txn)
);

`default_nettype wire

//--- testbench/tb_conflict_checker.sv
`include "cc_params.svh"

`default_nettype none

module tb_conflict_checker;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 100;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              s_valid;
    logic              s_ready;
    cc_pkg::cc_txn_t   s_txn;
    logic              m_valid;
    logic              m_ready;
    cc_pkg::cc_txn_t   m_txn;
    logic              batch_done;
    cc_pkg::cc_stats_t stats;

    // Reference model of the batch sets and the counters
    logic [`CC_DEP_WIDTH-1:0] model_rd;
    logic [`CC_DEP_WIDTH-1:0] model_wr;
    cc_pkg::cc_stats_t        exp_stats;
    cc_pkg::cc_txn_t          exp_q[$];

    integer seed = 32'h390dcef7;
    int     value_errors = 0;
    int     other_errors = 0;

    conflict_checker i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_txn      (s_txn),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_txn      (m_txn),
        .batch_done (batch_done),
        .stats      (stats)
    );

    always #4 clk = ~clk;

    function automatic cc_pkg::cc_verdict_t ref_verdict(input cc_pkg::cc_txn_t txn,
                                                        input logic [`CC_DEP_WIDTH-1:0] rd,
                                                        input logic [`CC_DEP_WIDTH-1:0] wr);
        cc_pkg::cc_verdict_t v;
        v.raw = |(txn.rd_deps & wr);
        v.waw = |(txn.wr_deps & wr);
        v.war = |(txn.wr_deps & rd);
        return v;
    endfunction

    function automatic logic [`CC_DEP_WIDTH-1:0] one_bit(input int n);
        return `CC_DEP_WIDTH'(1) << n;
    endfunction

    // Roughly one bit in 32 set, so overlaps happen but not always
    function automatic logic [`CC_DEP_WIDTH-1:0] sparse_deps();
        logic [`CC_DEP_WIDTH-1:0] d;
        for (int i = 0; i < `CC_DEP_WIDTH / 32; i++) begin
            d[i*32 +: 32] = $random(seed) & $random(seed) & $random(seed)
                          & $random(seed) & $random(seed);
        end
        return d;
    endfunction

    function automatic cc_pkg::cc_txn_t make_txn(input logic [`CC_OWNER_WIDTH-1:0] owner,
                                                 input logic [`CC_DEP_WIDTH-1:0] rd,
                                                 input logic [`CC_DEP_WIDTH-1:0] wr);
        cc_pkg::cc_txn_t t;
        t.owner   = owner;
        t.rd_deps = rd;
        t.wr_deps = wr;
        return t;
    endfunction

    task automatic check_txn(input string name, input cc_pkg::cc_txn_t got,
                             input cc_pkg::cc_txn_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_stats(input string name, input cc_pkg::cc_stats_t got,
                               input cc_pkg::cc_stats_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic wait_s_ready(input string what);
        int n = 0;
        @(negedge clk);
        while (!s_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_ready) begin
            other_errors++;
            $display("Timed out waiting for s_ready while %s", what);
        end
    endtask

    task automatic wait_m_valid();
        int n = 0;
        @(negedge clk);
        while (!m_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!m_valid) begin
            other_errors++;
            $display("Timed out waiting for m_valid on a clean transaction");
        end
    endtask

    // Offers one transaction, optionally stalls the sink, then waits for the loop to close
    task automatic send_txn(input cc_pkg::cc_txn_t txn, input int stall);
        cc_pkg::cc_verdict_t v;
        logic                clean;
        v = ref_verdict(txn, model_rd, model_wr);
        clean = !(v.raw || v.waw || v.war);
        exp_stats.processed_cnt = exp_stats.processed_cnt + 1;
        if (v.raw) begin
            exp_stats.raw_cnt = exp_stats.raw_cnt + 1;
        end
        if (v.waw) begin
            exp_stats.waw_cnt = exp_stats.waw_cnt + 1;
        end
        if (v.war) begin
            exp_stats.war_cnt = exp_stats.war_cnt + 1;
        end
        if (clean) begin
            exp_q.push_back(txn);
        end else begin
            exp_stats.filtered_cnt = exp_stats.filtered_cnt + 1;
        end
        @(posedge clk);
        #1;
        s_valid = 1'b1;
        s_txn   = txn;
        m_ready = (stall == 0);
        wait_s_ready("offering a transaction");
        @(posedge clk);
        #1;
        s_valid = 1'b0;
        if (clean && stall > 0) begin
            wait_m_valid();
            repeat (stall) begin
                check_bit("m_valid", m_valid, 1'b1);
                check_bit("s_ready", s_ready, 1'b0);
                check_txn("m_txn", m_txn, txn);
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            m_ready = 1'b1;
        end
        wait_s_ready("finishing a transaction");
        if (clean) begin
            model_rd = model_rd | txn.rd_deps;
            model_wr = model_wr | txn.wr_deps;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Clean transaction with owner %h was never forwarded", txn.owner);
            exp_q.delete();
        end
        check_stats("stats", stats, exp_stats);
    endtask

    task automatic end_batch();
        wait_s_ready("ending a batch");
        @(posedge clk);
        #1;
        batch_done = 1'b1;
        @(posedge clk);
        #1;
        batch_done = 1'b0;
        model_rd = '0;
        model_wr = '0;
    endtask

    // Output transfer happens on the next rising edge when both are high here
    always @(negedge clk) begin
        if (rst_n && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Transaction with owner %h forwarded but should have been dropped",
                         m_txn.owner);
            end else begin
                check_txn("m_txn", m_txn, exp_q.pop_front());
            end
        end
    end

    initial begin
        int              stall;
        cc_pkg::cc_txn_t t;
        rst_n      = 1'b0;
        s_valid    = 1'b0;
        s_txn      = '0;
        m_ready    = 1'b1;
        batch_done = 1'b0;
        model_rd   = '0;
        model_wr   = '0;
        exp_stats  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_stats("stats after reset", stats, exp_stats);

        // Disjoint sets with reads on bits 0/10/20/30 and writes on 5/15/25/35
        for (int i = 0; i < 4; i++) begin
            send_txn(make_txn(64'h100 + i, one_bit(10 * i), one_bit(10 * i + 5)), 0);
        end

        send_txn(make_txn(64'h200, one_bit(5), one_bit(200)), 0);
        send_txn(make_txn(64'h201, one_bit(100), one_bit(15)), 0);
        send_txn(make_txn(64'h202, one_bit(101), one_bit(20)), 0);
        // Hits RAW, WAW and WAR at once
        send_txn(make_txn(64'h203, one_bit(25), one_bit(30) | one_bit(35)), 0);

        // Bit 200 came from a dropped write, so this one is clean
        send_txn(make_txn(64'h204, one_bit(200), one_bit(201)), 0);

        stall = ($random(seed) & 7) + 2;
        send_txn(make_txn(64'h300, one_bit(250), one_bit(251)), stall);

        end_batch();
        check_stats("stats after batch_done", stats, exp_stats);
        send_txn(make_txn(64'h200, one_bit(5), one_bit(200)), 0);

        for (int i = 0; i < 40; i++) begin
            if (($random(seed) & 7) == 0) begin
                end_batch();
            end
            t = make_txn(64'h1000 + i, sparse_deps(), sparse_deps());
            stall = 0;
            if (($random(seed) & 3) == 0) begin
                stall = ($random(seed) & 3) + 1;
            end
            send_txn(t, stall);
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/cc_pkg.sv
conflict_engine/conflict_detect.sv
conflict_engine/dep_tracker.sv
src/txn_control.sv
src/perf_counters.sv
src/conflict_checker.sv
testbench/conflict_checker_chk.sv
testbench/tb_conflict_checker.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_conflict_checker \
    -f filelist.f \
    -o sim_conflict_checker
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_conflict_checker)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
